// ==== design/spi_sd_settings.svh ====
`ifndef SPI_SD_SETTINGS_SVH
`define SPI_SD_SETTINGS_SVH

// fifo depth is 2**log2, same for tx and rx
`define SPI_SD_FIFO_LOG2 4

// data path width, one sd byte
`define SPI_SD_DATA_W 8

// register word addresses
`define SPI_SD_ADDR_SCKDIV 8'h00
`define SPI_SD_ADDR_CTRL   8'h01 // write: count and crc, read: status
`define SPI_SD_ADDR_TXDATA 8'h02
`define SPI_SD_ADDR_RXDATA 8'h03

`endif

// ==== design/spi_sd_pkg.sv ====
`include "spi_sd_settings.svh"

package spi_sd_pkg;

    typedef logic [`SPI_SD_DATA_W-1:0] spi_byte_t;

    // transfer sequencer states, also visible in ctrl status
    typedef enum logic [1:0] {
        ST_IDLE      = 2'd0,
        ST_WAIT_EDGE = 2'd1,
        ST_SEND      = 2'd2,
        ST_ENDING    = 2'd3
    } xfer_state_e;

    // ctrl word as the host writes it
    typedef struct packed {
        logic [15:0] byte_cnt;
        logic [7:0]  rsvd_hi;
        logic        gen_crc;
        logic [6:0]  rsvd_lo;
    } ctrl_wr_t;

    // same address read back as status
    typedef struct packed {
        logic [15:0] byte_cnt;  // bytes still to send
        logic [7:0]  rsvd_hi;
        logic        gen_crc;
        logic        rsvd_6;
        xfer_state_e state;
        logic        rsvd_3;
        logic        miso;      // live input level
        logic        protect;
        logic        detected;
    } ctrl_rd_t;

    typedef union packed {
        ctrl_wr_t wr;
        ctrl_rd_t rd;
    } ctrl_word_u;

endpackage

// ==== design/spi_sd_fifo.sv ====
`include "spi_sd_settings.svh"

module spi_sd_fifo #(
    parameter int LOG2_DEPTH = `SPI_SD_FIFO_LOG2
) (
    input  logic                  i_clk,
    input  logic                  i_nrst,
    input  logic                  i_push,
    input  spi_sd_pkg::spi_byte_t i_wdata,
    input  logic                  i_pop,
    output spi_sd_pkg::spi_byte_t o_rdata,
    output logic                  o_full,
    output logic                  o_empty
);
    import spi_sd_pkg::*;

    localparam int DEPTH = 1 << LOG2_DEPTH;
    localparam int CNT_W = LOG2_DEPTH + 1;

    spi_byte_t             mem [DEPTH];
    logic [LOG2_DEPTH-1:0] wr_ptr;
    logic [LOG2_DEPTH-1:0] rd_ptr;
    logic [CNT_W-1:0]      count;
    logic                  push_ok;
    logic                  pop_ok;

    assign o_full  = (count == CNT_W'(DEPTH));
    assign o_empty = (count == '0);
    assign push_ok = i_push & ~o_full;   // full drops the push
    assign pop_ok  = i_pop & ~o_empty;
    assign o_rdata = mem[rd_ptr];        // head visible before the pop

    always_ff @(posedge i_clk) begin
        if (push_ok) begin
            mem[wr_ptr] <= i_wdata;
        end
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_ok) wr_ptr <= wr_ptr + 1'b1;  // pointers wrap naturally
            if (pop_ok) rd_ptr <= rd_ptr + 1'b1;
            count <= count + CNT_W'(push_ok) - CNT_W'(pop_ok);
        end
    end

    a_count_bound: assert property (@(posedge i_clk) disable iff (!i_nrst)
        count <= CNT_W'(DEPTH));

endmodule

// ==== design/spi_sd_clkdiv.sv ====
module spi_sd_clkdiv (
    input  logic        i_clk,
    input  logic        i_nrst,
    input  logic [31:0] i_divider,
    input  logic        i_load,
    output logic        o_level,
    output logic        o_rise,
    output logic        o_fall
);

    logic [31:0] cnt;
    logic        level;
    logic        tick;

    // zero divider parks the timer
    assign tick = (|i_divider) & (cnt == i_divider - 32'd1) & ~i_load;

    assign o_level = level;
    assign o_rise  = tick & ~level;
    assign o_fall  = tick & level;

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            cnt   <= '0;
            level <= 1'b1;  // first toggle is a fall, which opens a byte
        end else if (i_load) begin
            cnt <= '0;
        end else if (tick) begin
            cnt   <= '0;
            level <= ~level;
        end else if (|i_divider) begin
            cnt <= cnt + 32'd1;
        end
    end

    a_no_double_edge: assert property (@(posedge i_clk) disable iff (!i_nrst)
        !(o_rise && o_fall));

endmodule

// ==== design/spi_sd_shifter.sv ====
module spi_sd_shifter (
    input  logic                  i_clk,
    input  logic                  i_nrst,
    input  logic                  i_rise,
    input  logic                  i_fall,
    input  logic                  i_start,
    input  spi_sd_pkg::spi_byte_t i_tx_byte,
    input  logic                  i_crc_clear,
    input  logic                  i_miso,
    output logic                  o_mosi,
    output logic                  o_cs_active,
    output logic                  o_byte_done,
    output spi_sd_pkg::spi_byte_t o_rx_byte,
    output logic [6:0]            o_crc7
);
    import spi_sd_pkg::*;

    spi_byte_t  tx_shift;
    spi_byte_t  rx_shift;
    logic [2:0] bit_cnt;
    logic       cs;
    logic       pending;   // start seen, waiting for a fall
    logic       take;
    logic [6:0] crc7;
    logic [6:0] crc_nxt;
    logic       crc_fb;

    assign take   = i_fall & (i_start | pending);
    assign crc_fb = crc7[6] ^ tx_shift[7];

    // x^7 + x^3 + 1 over the bits driven on mosi
    always_comb begin
        crc_nxt = crc7;
        if (i_rise && cs) begin
            crc_nxt = {crc7[5:3], crc7[2] ^ crc_fb, crc7[1:0], crc_fb};
        end
    end

    assign o_mosi      = tx_shift[7];
    assign o_cs_active = cs;
    assign o_crc7      = crc_nxt;  // includes the bit sampled this cycle
    assign o_byte_done = i_rise & cs & (bit_cnt == 3'd0);
    assign o_rx_byte   = {rx_shift[6:0], i_miso};

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            tx_shift <= '0;
            bit_cnt  <= '0;
            cs       <= 1'b0;
            pending  <= 1'b0;
            crc7     <= '0;
        end else begin
            crc7 <= i_crc_clear ? 7'd0 : crc_nxt;
            if (take) begin
                pending <= 1'b0;
            end else if (i_start) begin
                pending <= 1'b1;
            end
            if (take) begin
                tx_shift <= i_tx_byte;
                bit_cnt  <= 3'd7;
                cs       <= 1'b1;
            end else if (i_fall && cs) begin
                tx_shift <= {tx_shift[6:0], 1'b1};
                if (|bit_cnt) begin
                    bit_cnt <= bit_cnt - 3'd1;
                end else begin
                    cs <= 1'b0;  // last bit done, nothing queued
                end
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rise && cs) rx_shift <= {rx_shift[6:0], i_miso};
    end

endmodule

// ==== design/spi_sd_xfer_fsm.sv ====
module spi_sd_xfer_fsm (
    input  logic                    i_clk,
    input  logic                    i_nrst,
    input  logic                    i_ctrl_load,
    input  logic [15:0]             i_ctrl_byte_cnt,
    input  logic                    i_ctrl_gen_crc,
    input  logic                    i_tx_empty,
    input  spi_sd_pkg::spi_byte_t   i_tx_data,
    input  logic                    i_byte_done,
    input  logic                    i_cs_active,
    input  logic [6:0]              i_crc7,
    output logic                    o_tx_pop,
    output logic                    o_start,
    output spi_sd_pkg::spi_byte_t   o_tx_byte,
    output logic                    o_crc_clear,
    output spi_sd_pkg::xfer_state_e o_state,
    output logic [15:0]             o_byte_cnt,
    output logic                    o_gen_crc
);
    import spi_sd_pkg::*;

    xfer_state_e state;
    logic [15:0] byte_cnt;
    logic        gen_crc;
    spi_byte_t   tx_val;
    logic        take_byte;
    logic        take_crc;

    // next byte comes from the fifo while the count lasts
    assign take_byte = (|byte_cnt) &
                       ((state == ST_IDLE) || (state == ST_SEND && i_byte_done));
    assign take_crc  = (state == ST_SEND) & i_byte_done & ~(|byte_cnt) & gen_crc;

    assign o_tx_pop    = take_byte & ~i_tx_empty;
    assign o_crc_clear = (state == ST_IDLE) & (|byte_cnt);
    assign o_start     = (state == ST_WAIT_EDGE);  // shifter holds it until a fall
    assign o_tx_byte   = tx_val;
    assign o_state     = state;
    assign o_byte_cnt  = byte_cnt;
    assign o_gen_crc   = gen_crc;

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            state    <= ST_IDLE;
            byte_cnt <= '0;
            gen_crc  <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (take_byte) state <= ST_WAIT_EDGE;
                end
                ST_WAIT_EDGE: state <= ST_SEND;
                ST_SEND: begin
                    if (take_byte || take_crc) begin
                        state <= ST_WAIT_EDGE;
                    end else if (i_byte_done) begin
                        state <= ST_ENDING;
                    end
                end
                default: begin
                    if (!i_cs_active) state <= ST_IDLE;  // cs dropped on the last fall
                end
            endcase
            if (take_byte) byte_cnt <= byte_cnt - 16'd1;
            if (take_crc) gen_crc <= 1'b0;
            if (i_ctrl_load) begin  // host write wins
                byte_cnt <= i_ctrl_byte_cnt;
                gen_crc  <= i_ctrl_gen_crc;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (take_byte) begin
            tx_val <= i_tx_empty ? 8'hFF : i_tx_data;  // dry fifo sends idle ones
        end else if (take_crc) begin
            tx_val <= {i_crc7, 1'b1};
        end
    end

    a_idle_no_cs: assert property (@(posedge i_clk) disable iff (!i_nrst)
        (state == ST_IDLE) |-> !i_cs_active);

endmodule

// ==== design/spi_sd_regs.sv ====
`include "spi_sd_settings.svh"

module spi_sd_regs (
    input  logic                    i_clk,
    input  logic                    i_nrst,
    input  logic                    i_req_valid,
    input  logic [7:0]              i_req_addr,
    input  logic                    i_req_write,
    input  logic [31:0]             i_req_wdata,
    output logic                    o_resp_valid,
    output logic [31:0]             o_resp_rdata,
    input  logic                    i_miso,
    input  logic                    i_detected,
    input  logic                    i_protect,
    input  spi_sd_pkg::xfer_state_e i_state,
    input  logic [15:0]             i_byte_cnt,
    input  logic                    i_gen_crc,
    input  logic                    i_tx_full,
    input  logic                    i_rx_empty,
    input  spi_sd_pkg::spi_byte_t   i_rx_data,
    output logic [31:0]             o_divider,
    output logic                    o_div_load,
    output logic                    o_ctrl_load,
    output logic [15:0]             o_ctrl_byte_cnt,
    output logic                    o_ctrl_gen_crc,
    output logic                    o_tx_push,
    output spi_sd_pkg::spi_byte_t   o_tx_data,
    output logic                    o_rx_pop
);
    import spi_sd_pkg::*;

    logic        wr_req;
    logic        rd_req;
    logic [31:0] divider;
    ctrl_word_u  cmd;
    ctrl_word_u  status;
    logic [31:0] rdata;

    assign wr_req = i_req_valid & i_req_write;
    assign rd_req = i_req_valid & ~i_req_write;
    assign cmd    = i_req_wdata;

    assign o_divider       = divider;
    assign o_div_load      = wr_req & (i_req_addr == `SPI_SD_ADDR_SCKDIV);
    assign o_ctrl_load     = wr_req & (i_req_addr == `SPI_SD_ADDR_CTRL);
    assign o_ctrl_byte_cnt = cmd.wr.byte_cnt;
    assign o_ctrl_gen_crc  = cmd.wr.gen_crc;
    assign o_tx_push       = wr_req & (i_req_addr == `SPI_SD_ADDR_TXDATA) & ~i_tx_full;
    assign o_tx_data       = i_req_wdata[7:0];
    assign o_rx_pop        = rd_req & (i_req_addr == `SPI_SD_ADDR_RXDATA) & ~i_rx_empty;

    always_comb begin
        status                = '0;
        status.rd.byte_cnt    = i_byte_cnt;
        status.rd.gen_crc     = i_gen_crc;
        status.rd.state       = i_state;
        status.rd.miso        = i_miso;
        status.rd.protect     = i_protect;
        status.rd.detected    = i_detected;
        rdata = '0;
        case (i_req_addr)
            `SPI_SD_ADDR_SCKDIV: rdata = divider;
            `SPI_SD_ADDR_CTRL:   rdata = status;
            `SPI_SD_ADDR_TXDATA: rdata[31] = i_tx_full;
            `SPI_SD_ADDR_RXDATA: begin
                rdata[31]  = i_rx_empty;
                rdata[7:0] = i_rx_data;  // head byte, popped this cycle
            end
            default: rdata = '0;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            divider      <= '0;
            o_resp_valid <= 1'b0;
        end else begin
            if (o_div_load) divider <= i_req_wdata;
            o_resp_valid <= i_req_valid;
        end
    end

    // writes answer with zero
    always_ff @(posedge i_clk) begin
        o_resp_rdata <= i_req_write ? 32'd0 : rdata;
    end

    a_one_cycle_resp: assert property (@(posedge i_clk) disable iff (!i_nrst)
        i_req_valid |=> o_resp_valid);

endmodule

// ==== design/spi_sd_top.sv ====
`include "spi_sd_settings.svh"

module spi_sd_top (
    input  logic        i_clk,
    input  logic        i_nrst,
    input  logic        i_req_valid,
    input  logic [7:0]  i_req_addr,
    input  logic        i_req_write,
    input  logic [31:0] i_req_wdata,
    output logic        o_resp_valid,
    output logic [31:0] o_resp_rdata,
    output logic        o_cs_n,
    output logic        o_sclk,
    output logic        o_mosi,
    input  logic        i_miso,
    input  logic        i_detected,
    input  logic        i_protect
);
    import spi_sd_pkg::*;

    logic [31:0] divider;
    logic        div_load, ctrl_load, ctrl_gen_crc;
    logic [15:0] ctrl_byte_cnt, byte_cnt;
    logic        gen_crc, tx_push, tx_pop, tx_full, tx_empty, rx_pop, rx_empty;
    spi_byte_t   tx_wdata, tx_head, rx_head, shift_tx_byte, rx_byte;
    logic        level, rise, fall, start, crc_clear, cs_active, byte_done;
    logic [6:0]  crc7;
    xfer_state_e state;

    assign o_sclk = level & cs_active;  // clock only shows inside cs
    assign o_cs_n = ~cs_active;

    spi_sd_regs u_regs (
        .i_clk(i_clk), .i_nrst(i_nrst), .i_req_valid(i_req_valid), .i_req_addr(i_req_addr),
        .i_req_write(i_req_write), .i_req_wdata(i_req_wdata), .o_resp_valid(o_resp_valid),
        .o_resp_rdata(o_resp_rdata), .i_miso(i_miso), .i_detected(i_detected),
        .i_protect(i_protect), .i_state(state), .i_byte_cnt(byte_cnt), .i_gen_crc(gen_crc),
        .i_tx_full(tx_full), .i_rx_empty(rx_empty), .i_rx_data(rx_head), .o_divider(divider),
        .o_div_load(div_load), .o_ctrl_load(ctrl_load), .o_ctrl_byte_cnt(ctrl_byte_cnt),
        .o_ctrl_gen_crc(ctrl_gen_crc), .o_tx_push(tx_push), .o_tx_data(tx_wdata),
        .o_rx_pop(rx_pop));

    spi_sd_fifo #(.LOG2_DEPTH(`SPI_SD_FIFO_LOG2)) tx_fifo (
        .i_clk(i_clk), .i_nrst(i_nrst), .i_push(tx_push), .i_wdata(tx_wdata), .i_pop(tx_pop),
        .o_rdata(tx_head), .o_full(tx_full), .o_empty(tx_empty));

    spi_sd_fifo #(.LOG2_DEPTH(`SPI_SD_FIFO_LOG2)) rx_fifo (
        .i_clk(i_clk), .i_nrst(i_nrst), .i_push(byte_done), .i_wdata(rx_byte), .i_pop(rx_pop),
        .o_rdata(rx_head), .o_full(), .o_empty(rx_empty));

    spi_sd_clkdiv u_clkdiv (
        .i_clk(i_clk), .i_nrst(i_nrst), .i_divider(divider), .i_load(div_load),
        .o_level(level), .o_rise(rise), .o_fall(fall));

    spi_sd_shifter u_shifter (
        .i_clk(i_clk), .i_nrst(i_nrst), .i_rise(rise), .i_fall(fall), .i_start(start),
        .i_tx_byte(shift_tx_byte), .i_crc_clear(crc_clear), .i_miso(i_miso), .o_mosi(o_mosi),
        .o_cs_active(cs_active), .o_byte_done(byte_done), .o_rx_byte(rx_byte), .o_crc7(crc7));

    spi_sd_xfer_fsm u_fsm (
        .i_clk(i_clk), .i_nrst(i_nrst), .i_ctrl_load(ctrl_load),
        .i_ctrl_byte_cnt(ctrl_byte_cnt), .i_ctrl_gen_crc(ctrl_gen_crc), .i_tx_empty(tx_empty),
        .i_tx_data(tx_head), .i_byte_done(byte_done), .i_cs_active(cs_active), .i_crc7(crc7),
        .o_tx_pop(tx_pop), .o_start(start), .o_tx_byte(shift_tx_byte), .o_crc_clear(crc_clear),
        .o_state(state), .o_byte_cnt(byte_cnt), .o_gen_crc(gen_crc));

endmodule

// ==== verif/spi_sd_tb.sv ====
`include "spi_sd_settings.svh"

module spi_sd_tb;
    import spi_sd_pkg::*;

    // 6 transfers x 20 bytes x 64 cycles, plus margin for polling
    localparam int CYCLE_LIMIT = 20000;
    localparam int FIFO_DEPTH  = 1 << `SPI_SD_FIFO_LOG2;

    logic        i_clk;
    logic        i_nrst;
    logic        i_req_valid;
    logic [7:0]  i_req_addr;
    logic        i_req_write;
    logic [31:0] i_req_wdata;
    logic        o_resp_valid;
    logic [31:0] o_resp_rdata;
    logic        o_cs_n;
    logic        o_sclk;
    logic        o_mosi;
    logic        i_miso;
    logic        i_detected;
    logic        i_protect;

    int          mismatch_cnt;
    int          fail_cnt;
    int          cycle_cnt;
    spi_byte_t   tx_q[$];     // model of the tx fifo
    spi_byte_t   rx_q[$];     // bytes expected back
    logic        mosi_idle;   // rests high once a byte has gone out
    logic        mon_on;
    logic        prev_sclk;
    logic        prev_cs_n;
    int          sclk_rises;
    int          cs_n_rises;
    logic [31:0] rd;
    logic [31:0] div;
    ctrl_word_u  cmd;
    ctrl_word_u  exp_ctrl;
    int          n;

    assign i_miso = o_mosi;  // loopback

    spi_sd_top DUT (
        .i_clk(i_clk), .i_nrst(i_nrst), .i_req_valid(i_req_valid), .i_req_addr(i_req_addr),
        .i_req_write(i_req_write), .i_req_wdata(i_req_wdata), .o_resp_valid(o_resp_valid),
        .o_resp_rdata(o_resp_rdata), .o_cs_n(o_cs_n), .o_sclk(o_sclk), .o_mosi(o_mosi),
        .i_miso(i_miso), .i_detected(i_detected), .i_protect(i_protect));

    always #2 i_clk = ~i_clk;

    always @(posedge i_clk) begin
        cycle_cnt++;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("errors: %0d mismatches, %0d other", mismatch_cnt, fail_cnt + 1);
            $display("Verification failed");
            $finish;
        end
    end

    // spi pin watcher, sampled mid-cycle
    always @(negedge i_clk) begin
        if (mon_on) begin
            if (o_sclk && !prev_sclk) sclk_rises++;
            if (o_cs_n && !prev_cs_n) cs_n_rises++;
            if (o_sclk && o_cs_n) begin
                fail_cnt++;
                $display("t=%0t sclk is high while chip select is inactive", $time);
            end
        end
        prev_sclk = o_sclk;
        prev_cs_n = o_cs_n;
    end

    task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            mismatch_cnt++;
            $display("MISMATCH t=%0t %s got %08h expected %08h", $time, name, got, exp);
        end
    endtask

    task automatic check_byte(input string name, input spi_byte_t got, input spi_byte_t exp);
        if (got !== exp) begin
            mismatch_cnt++;
            $display("MISMATCH t=%0t %s got %02h expected %02h", $time, name, got, exp);
        end
    endtask

    task automatic check_ctrl(input string name, input ctrl_word_u got, input ctrl_word_u exp);
        if (got !== exp) begin
            mismatch_cnt++;
            $display("MISMATCH t=%0t %s got %08h expected %08h", $time, name, got, exp);
        end
    endtask

    // one request, response captured the cycle after
    task automatic bus_access(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                              output logic [31:0] rdata);
        @(posedge i_clk);
        #1;
        i_req_valid = 1'b1;
        i_req_write = wr;
        i_req_addr  = addr;
        i_req_wdata = wdata;
        @(posedge i_clk);
        #1;
        i_req_valid = 1'b0;
        i_req_write = 1'b0;
        @(negedge i_clk);
        if (o_resp_valid !== 1'b1) begin
            fail_cnt++;
            $display("t=%0t no response one cycle after request to address %0d", $time, addr);
        end
        rdata = o_resp_rdata;
        if (wr) check_word("o_resp_rdata on write", rdata, 32'd0);
    endtask

    task automatic reg_write(input logic [7:0] addr, input logic [31:0] wdata);
        logic [31:0] unused;
        bus_access(1'b1, addr, wdata, unused);
    endtask

    task automatic reg_read(input logic [7:0] addr, output logic [31:0] rdata);
        bus_access(1'b0, addr, 32'd0, rdata);
    endtask

    task automatic push_tx(input spi_byte_t b);
        reg_write(`SPI_SD_ADDR_TXDATA, {24'd0, b});
        if (tx_q.size() < FIFO_DEPTH) tx_q.push_back(b);  // full fifo drops it
    endtask

    function automatic logic [6:0] crc7_update(input logic [6:0] crc, input spi_byte_t b);
        logic fb;
        for (int i = 7; i >= 0; i--) begin
            fb  = crc[6] ^ b[i];
            crc = {crc[5:0], 1'b0};
            if (fb) crc = crc ^ 7'h09;  // x^3 + 1 taps
        end
        return crc;
    endfunction

    task automatic run_transfer(input int cnt, input logic use_crc);
        ctrl_word_u  wr_word;
        ctrl_word_u  st;
        ctrl_word_u  exp;
        logic [31:0] data;
        logic [6:0]  crc;
        spi_byte_t   b;
        @(posedge i_clk);
        #1;
        i_detected = 1'($urandom_range(1, 0));
        i_protect  = 1'($urandom_range(1, 0));
        crc = '0;
        for (int i = 0; i < cnt; i++) begin
            if (tx_q.size() > 0) begin
                b = tx_q.pop_front();
            end else begin
                b = 8'hFF;  // dry fifo
            end
            crc = crc7_update(crc, b);
            rx_q.push_back(b);
        end
        if (use_crc) rx_q.push_back({crc, 1'b1});
        wr_word             = '0;
        wr_word.wr.byte_cnt = 16'(cnt);
        wr_word.wr.gen_crc  = use_crc;
        reg_write(`SPI_SD_ADDR_CTRL, wr_word);
        do begin
            reg_read(`SPI_SD_ADDR_CTRL, data);
            st = data;
        end while (!(st.rd.state == ST_IDLE && st.rd.byte_cnt == 16'd0));
        mosi_idle       = 1'b1;
        exp             = '0;
        exp.rd.state    = ST_IDLE;
        exp.rd.miso     = mosi_idle;
        exp.rd.protect  = i_protect;
        exp.rd.detected = i_detected;
        check_ctrl("ctrl status after transfer", st, exp);
    endtask

    task automatic drain_rx(input string tag);
        logic [31:0] data;
        spi_byte_t   exp;
        while (rx_q.size() > 0) begin
            exp = rx_q.pop_front();
            reg_read(`SPI_SD_ADDR_RXDATA, data);
            check_word({tag, " rx empty flag"}, data & 32'h8000_0000, 32'd0);
            check_byte({tag, " rx byte"}, data[7:0], exp);
        end
        reg_read(`SPI_SD_ADDR_RXDATA, data);
        check_word({tag, " rx empty at end"}, data & 32'h8000_0000, 32'h8000_0000);
    endtask

    task automatic load_random(input int count);
        for (int i = 0; i < count; i++) push_tx(8'($urandom));
    endtask

    initial begin
        i_clk        = 1'b0;
        i_nrst       = 1'b0;
        i_req_valid  = 1'b0;
        i_req_addr   = '0;
        i_req_write  = 1'b0;
        i_req_wdata  = '0;
        mismatch_cnt = 0;
        fail_cnt     = 0;
        cycle_cnt    = 0;
        mosi_idle    = 1'b0;
        mon_on       = 1'b0;
        void'($urandom(20480));
        i_detected = 1'($urandom_range(1, 0));
        i_protect  = 1'($urandom_range(1, 0));
        repeat (2) @(posedge i_clk);
        #1;
        i_nrst = 1'b1;

        // reset values and divider readback
        @(negedge i_clk);
        check_word("o_cs_n", 32'(o_cs_n), 32'd1);
        check_word("o_sclk", 32'(o_sclk), 32'd0);
        reg_read(`SPI_SD_ADDR_RXDATA, rd);
        check_word("rxdata empty after reset", rd & 32'h8000_0000, 32'h8000_0000);
        div = $urandom;
        reg_write(`SPI_SD_ADDR_SCKDIV, div);
        reg_read(`SPI_SD_ADDR_SCKDIV, rd);
        check_word("sckdiv", rd, div);

        // ctrl write then status view
        cmd            = '0;
        cmd.wr.gen_crc = 1'b1;
        reg_write(`SPI_SD_ADDR_CTRL, cmd);
        reg_read(`SPI_SD_ADDR_CTRL, rd);
        exp_ctrl             = '0;
        exp_ctrl.rd.gen_crc  = 1'b1;
        exp_ctrl.rd.state    = ST_IDLE;
        exp_ctrl.rd.miso     = mosi_idle;
        exp_ctrl.rd.protect  = i_protect;
        exp_ctrl.rd.detected = i_detected;
        check_ctrl("ctrl readback", rd, exp_ctrl);

        repeat (3) begin
            reg_write(`SPI_SD_ADDR_SCKDIV, 32'($urandom_range(4, 1)));
            n = $urandom_range(12, 1);
            load_random(n);
            run_transfer(n, 1'b0);
            drain_rx("random");
        end

        // more bytes asked than loaded
        n = $urandom_range(3, 0);
        load_random(n);
        run_transfer(n + $urandom_range(4, 1), 1'b0);
        drain_rx("underflow");

        // crc byte appended, pins watched
        n = $urandom_range(12, 1);
        load_random(n);
        sclk_rises = 0;
        cs_n_rises = 0;
        mon_on     = 1'b1;
        run_transfer(n, 1'b1);
        mon_on = 1'b0;
        check_word("sclk rising edges", 32'(sclk_rises), 32'(8 * (n + 1)));
        check_word("cs_n rising edges", 32'(cs_n_rises), 32'd1);
        drain_rx("crc");

        for (int i = 0; i < FIFO_DEPTH + 1; i++) push_tx(8'($urandom));
        reg_read(`SPI_SD_ADDR_TXDATA, rd);
        check_word("txdata full flag", rd & 32'h8000_0000,
                   (tx_q.size() == FIFO_DEPTH) ? 32'h8000_0000 : 32'd0);
        run_transfer(FIFO_DEPTH, 1'b0);
        drain_rx("full");

        $display("errors: %0d mismatches, %0d other", mismatch_cnt, fail_cnt);
        if (mismatch_cnt == 0 && fail_cnt == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// ==== spi_sd.f ====
+incdir+design
design/spi_sd_pkg.sv
design/spi_sd_fifo.sv
design/spi_sd_clkdiv.sv
design/spi_sd_shifter.sv
design/spi_sd_xfer_fsm.sv
design/spi_sd_regs.sv
design/spi_sd_top.sv
verif/spi_sd_tb.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := spi_sd_tb
FILELIST  := spi_sd.f
BIN       := obj_dir/V$(TOP)
SRCS      := $(wildcard design/*.sv design/*.svh verif/*.sv)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "Verification passed"

clean:
	rm -rf obj_dir
